// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - src/rv_isa_pkg.sv
  - src/core_pipe_pkg.sv
  - src/fetch_unit.sv
  - src/decoder.sv
  - src/regfile.sv
  - src/alu.sv
  - src/bru.sv
  - src/committer.sv
  - src/rv_core.sv
  - target: test
    files:
      - tests/tb_rv_core.sv

// ==== list.f ====
src/rv_isa_pkg.sv
src/core_pipe_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/regfile.sv
src/alu.sv
src/bru.sv
src/committer.sv
src/rv_core.sv
tests/tb_rv_core.sv

// ==== src/alu.sv ====
// Always ready; one result per accepted op exactly one cycle later, shifts use b[4:0]
module alu
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    in_valid,
  output logic    in_ready,
  input  alu_in_t in,
  output logic    out_valid,
  output wb_t     out
);

  word_t      result;
  logic [4:0] shamt;

  assign in_ready = 1'b1;
  assign shamt    = in.b[4:0];

  always_comb begin
    case (in.alu_op)
      ADD:     result = in.a + in.b;
      SUB:     result = in.a - in.b;
      SLL:     result = in.a << shamt;
      SLT:     result = {{(XLEN-1){1'b0}}, $signed(in.a) < $signed(in.b)};
      SLTU:    result = {{(XLEN-1){1'b0}}, in.a < in.b};
      XOR:     result = in.a ^ in.b;
      SRL:     result = in.a >> shamt;
      SRA:     result = word_t'($signed(in.a) >>> shamt);
      OR:      result = in.a | in.b;
      AND:     result = in.a & in.b;
      default: result = in.b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid && in_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out.pc        <= in.pc;
      out.rd        <= in.rd;
      out.writes_rd <= in.writes_rd;
      out.value     <= result;
    end
  end

endmodule

// ==== src/bru.sv ====
// Always ready; resolves one branch or jump per cycle, no misaligned-target trap
module bru
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      in_valid,
  output logic      in_ready,
  input  bru_in_t   in,
  output logic      out_valid,
  output wb_t       out,
  output redirect_t redirect
);

  logic  taken;
  word_t jalr_sum;
  word_t target;

  assign in_ready = 1'b1;
  assign jalr_sum = in.rs1_val + in.imm;
  assign target   = (in.bru_op == JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : in.pc + in.imm;

  always_comb begin
    case (in.bru_op)
      BEQ:     taken = (in.rs1_val == in.rs2_val);
      BNE:     taken = (in.rs1_val != in.rs2_val);
      BLT:     taken = ($signed(in.rs1_val) < $signed(in.rs2_val));
      BGE:     taken = ($signed(in.rs1_val) >= $signed(in.rs2_val));
      BLTU:    taken = (in.rs1_val < in.rs2_val);
      BGEU:    taken = (in.rs1_val >= in.rs2_val);
      default: taken = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid && in_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out.pc          <= in.pc;
      out.rd          <= in.rd;
      out.writes_rd   <= in.writes_rd;
      // Link value
      out.value       <= in.pc + word_t'(4);
      redirect.target <= target;
      redirect.taken  <= taken;
    end
  end

endmodule

// ==== src/committer.sv ====
// Purely combinational; relies on in-order issue so at most one unit result arrives per cycle
module committer
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic      alu_valid,
  input  wb_t       alu,
  input  logic      bru_valid,
  input  wb_t       bru,
  input  redirect_t redirect,
  output logic      wb_valid,
  output wb_t       wb,
  output logic      commit_valid,
  output wb_t       commit,
  output logic      invalidate,
  output word_t     redirect_pc
);

  wb_t  retired;
  logic retire;

  always_comb begin
    retire  = alu_valid || bru_valid;
    retired = bru_valid ? bru : alu;
  end

  // Register write port
  assign wb_valid = retire;
  assign wb       = retired;

  // Trace of every retired instruction
  assign commit_valid = retire;
  assign commit       = retired;

  // Taken branch or jump flushes everything younger
  assign invalidate  = bru_valid && redirect.taken;
  assign redirect_pc = redirect.target;

endmodule

// ==== src/core_pipe_pkg.sv ====
// Stage payloads of the in-order core; RESET_VECTOR must be word aligned
package core_pipe_pkg;

  import rv_isa_pkg::*;

  localparam word_t RESET_VECTOR = 32'h0000_0100;

  typedef struct packed {
    word_t addr;
  } fetch_req_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } ifid_t;

  typedef struct packed {
    word_t      pc;
    exec_unit_t unit;
    alu_op_t    alu_op;
    bru_op_t    bru_op;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm;
    logic       use_imm;
    logic       use_pc;
    logic       writes_rd;
  } idrf_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    logic     writes_rd;
    alu_op_t  alu_op;
    word_t    a;
    word_t    b;
  } alu_in_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    logic     writes_rd;
    bru_op_t  bru_op;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    imm;
  } bru_in_t;

  // Unit result, also the commit trace entry
  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    logic     writes_rd;
    word_t    value;
  } wb_t;

  typedef struct packed {
    word_t target;
    logic  taken;
  } redirect_t;

endpackage

// ==== src/decoder.sv ====
// Unsupported encodings decode as ALU ops with writes_rd low; writes to x0 are reported as no write
module decoder
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  output logic  in_ready,
  input  ifid_t in,
  output logic  out_valid,
  input  logic  out_ready,
  output idrf_t out,
  input  logic  invalidate
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      imm_j;
  idrf_t      dec;
  logic       in_fire;

  function automatic alu_op_t alu_op_of(logic [2:0] f3, logic alt_bit, logic is_reg);
    case (f3)
      3'b000:  return (is_reg && alt_bit) ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return alt_bit ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  assign opcode = in.instr[6:0];
  assign funct3 = in.instr[14:12];
  assign alt    = in.instr[30];

  assign imm_i = {{20{in.instr[31]}}, in.instr[31:20]};
  assign imm_u = {in.instr[31:12], 12'b0};
  assign imm_b = {{19{in.instr[31]}}, in.instr[31], in.instr[7], in.instr[30:25],
                  in.instr[11:8], 1'b0};
  assign imm_j = {{11{in.instr[31]}}, in.instr[31], in.instr[19:12], in.instr[20],
                  in.instr[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    dec.pc     = in.pc;
    dec.unit   = UNIT_ALU;
    dec.alu_op = ADD;
    dec.bru_op = BEQ;
    dec.rs1    = in.instr[19:15];
    dec.rs2    = in.instr[24:20];
    dec.rd     = in.instr[11:7];
    dec.imm    = imm_i;
    case (opcode)
      OPC_OP: begin
        dec.alu_op    = alu_op_of(funct3, alt, 1'b1);
        dec.writes_rd = 1'b1;
      end
      OPC_OP_IMM: begin
        dec.alu_op    = alu_op_of(funct3, alt, 1'b0);
        dec.rs2       = '0;
        dec.use_imm   = 1'b1;
        dec.writes_rd = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        dec.alu_op    = (opcode == OPC_LUI) ? PASS_B : ADD;
        dec.rs1       = '0;
        dec.rs2       = '0;
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.use_pc    = (opcode == OPC_AUIPC);
        dec.writes_rd = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        dec.unit      = UNIT_BRU;
        dec.bru_op    = (opcode == OPC_JAL) ? JAL : JALR;
        dec.rs1       = (opcode == OPC_JAL) ? reg_idx_t'(0) : in.instr[19:15];
        dec.rs2       = '0;
        dec.imm       = (opcode == OPC_JAL) ? imm_j : imm_i;
        dec.writes_rd = 1'b1;
      end
      OPC_BRANCH: begin
        dec.unit = UNIT_BRU;
        dec.rd   = '0;
        dec.imm  = imm_b;
        case (funct3)
          3'b000:  dec.bru_op = BEQ;
          3'b001:  dec.bru_op = BNE;
          3'b100:  dec.bru_op = BLT;
          3'b101:  dec.bru_op = BGE;
          3'b110:  dec.bru_op = BLTU;
          3'b111:  dec.bru_op = BGEU;
          default: dec.unit   = UNIT_ALU;
        endcase
      end
      default: begin
        dec.rs1 = '0;
        dec.rs2 = '0;
        dec.rd  = '0;
      end
    endcase
    if (dec.rd == '0) begin
      dec.writes_rd = 1'b0;
    end
  end

  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset || invalidate) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      out <= dec;
    end
  end

endmodule

// ==== src/fetch_unit.sv ====
// Single outstanding fetch; the memory must answer each request exactly once, a cycle or more later
module fetch_unit
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output logic  imem_req,
  output word_t imem_addr,
  input  logic  imem_rsp,
  input  word_t imem_data,
  output logic  out_valid,
  input  logic  out_ready,
  output ifid_t out,
  input  logic  invalidate,
  input  word_t redirect_pc
);

  word_t      pc_q;
  fetch_req_t pend_q;
  logic       busy_q;
  logic       stale_q;
  logic       drop_rsp;
  logic       take_rsp;
  logic       slot_free;

  assign imem_addr = pc_q;
  // Response to a request made before the last flush
  assign drop_rsp  = imem_rsp && (stale_q || invalidate);
  assign take_rsp  = imem_rsp && busy_q && !drop_rsp;
  // Buffer empty or draining, so the next response has room
  assign slot_free = invalidate || !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q      <= RESET_VECTOR;
      imem_req  <= 1'b0;
      busy_q    <= 1'b0;
      stale_q   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      imem_req <= !imem_req && (!busy_q || drop_rsp) && slot_free;

      if (imem_req) begin
        busy_q <= 1'b1;
      end else if (imem_rsp) begin
        busy_q <= 1'b0;
      end

      if (invalidate && (imem_req || (busy_q && !imem_rsp))) begin
        stale_q <= 1'b1;
      end else if (imem_rsp) begin
        stale_q <= 1'b0;
      end

      if (invalidate) begin
        pc_q <= redirect_pc;
      end else if (imem_req) begin
        pc_q <= pc_q + word_t'(4);
      end

      if (invalidate) begin
        out_valid <= 1'b0;
      end else if (take_rsp) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (imem_req) begin
      pend_q.addr <= pc_q;
    end
    if (take_rsp) begin
      out.pc    <= pend_q.addr;
      out.instr <= imem_data;
    end
  end

endmodule

// ==== src/regfile.sv ====
// Stalls on any busy source or destination; no forwarding, writes visible a cycle later
module regfile
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    in_valid,
  output logic    in_ready,
  input  idrf_t   in,
  output logic    alu_valid,
  input  logic    alu_ready,
  output alu_in_t alu,
  output logic    bru_valid,
  input  logic    bru_ready,
  output bru_in_t bru,
  input  logic    wb_valid,
  input  wb_t     wb,
  input  logic    invalidate
);

  word_t       regs [32];
  logic [31:0] busy_q;
  idrf_t       q;
  logic        valid_q;
  word_t       rs1_val;
  word_t       rs2_val;
  logic        hazard;
  logic        can_issue;
  logic        issue;

  assign rs1_val = (q.rs1 == '0) ? '0 : regs[q.rs1];
  assign rs2_val = (q.rs2 == '0) ? '0 : regs[q.rs2];

  assign hazard    = busy_q[q.rs1] || busy_q[q.rs2] || (q.writes_rd && busy_q[q.rd]);
  // Nothing issues in the flush cycle, so no wrong-path op reaches a unit
  assign can_issue = valid_q && !hazard && !invalidate;
  assign alu_valid = can_issue && (q.unit == UNIT_ALU);
  assign bru_valid = can_issue && (q.unit == UNIT_BRU);
  assign issue     = (alu_valid && alu_ready) || (bru_valid && bru_ready);
  assign in_ready  = !valid_q || issue;

  always_comb begin
    alu.pc        = q.pc;
    alu.rd        = q.rd;
    alu.writes_rd = q.writes_rd;
    alu.alu_op    = q.alu_op;
    alu.a         = q.use_pc ? q.pc : rs1_val;
    alu.b         = q.use_imm ? q.imm : rs2_val;
    bru.pc        = q.pc;
    bru.rd        = q.rd;
    bru.writes_rd = q.writes_rd;
    bru.bru_op    = q.bru_op;
    bru.rs1_val   = rs1_val;
    bru.rs2_val   = rs2_val;
    bru.imm       = q.imm;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      if (wb_valid && wb.writes_rd) begin
        busy_q[wb.rd] <= 1'b0;
      end
      if (issue && q.writes_rd && (q.rd != '0)) begin
        busy_q[q.rd] <= 1'b1;
      end
      if (invalidate) begin
        valid_q <= 1'b0;
      end else if (in_valid && in_ready) begin
        valid_q <= 1'b1;
      end else if (issue) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      q <= in;
    end
    if (wb_valid && wb.writes_rd && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.value;
    end
  end

endmodule

// ==== src/rv_core.sv ====
// RV32I subset core; instruction fetch only, no data memory port, branches predicted not taken
module rv_core
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output logic  imem_req,
  output word_t imem_addr,
  input  logic  imem_rsp,
  input  word_t imem_data,
  output logic  commit_valid,
  output wb_t   commit
);

  logic      ifid_valid;
  logic      ifid_ready;
  ifid_t     ifid;
  logic      idrf_valid;
  logic      idrf_ready;
  idrf_t     idrf;
  logic      rfalu_valid;
  logic      rfalu_ready;
  alu_in_t   rfalu;
  logic      rfbru_valid;
  logic      rfbru_ready;
  bru_in_t   rfbru;
  logic      aluwb_valid;
  wb_t       aluwb;
  logic      bruwb_valid;
  wb_t       bruwb;
  redirect_t bru_redirect;
  logic      wb_valid;
  wb_t       wb;
  logic      invalidate;
  word_t     redirect_pc;

  fetch_unit fetch_unit_inst (
    .clk(clk),
    .reset(reset),
    .imem_req(imem_req),
    .imem_addr(imem_addr),
    .imem_rsp(imem_rsp),
    .imem_data(imem_data),
    .out_valid(ifid_valid),
    .out_ready(ifid_ready),
    .out(ifid),
    .invalidate(invalidate),
    .redirect_pc(redirect_pc)
  );

  decoder decoder_inst (
    .clk(clk),
    .reset(reset),
    .in_valid(ifid_valid),
    .in_ready(ifid_ready),
    .in(ifid),
    .out_valid(idrf_valid),
    .out_ready(idrf_ready),
    .out(idrf),
    .invalidate(invalidate)
  );

  regfile regfile_inst (
    .clk(clk),
    .reset(reset),
    .in_valid(idrf_valid),
    .in_ready(idrf_ready),
    .in(idrf),
    .alu_valid(rfalu_valid),
    .alu_ready(rfalu_ready),
    .alu(rfalu),
    .bru_valid(rfbru_valid),
    .bru_ready(rfbru_ready),
    .bru(rfbru),
    .wb_valid(wb_valid),
    .wb(wb),
    .invalidate(invalidate)
  );

  alu alu_inst (
    .clk(clk),
    .reset(reset),
    .in_valid(rfalu_valid),
    .in_ready(rfalu_ready),
    .in(rfalu),
    .out_valid(aluwb_valid),
    .out(aluwb)
  );

  bru bru_inst (
    .clk(clk),
    .reset(reset),
    .in_valid(rfbru_valid),
    .in_ready(rfbru_ready),
    .in(rfbru),
    .out_valid(bruwb_valid),
    .out(bruwb),
    .redirect(bru_redirect)
  );

  committer committer_inst (
    .alu_valid(aluwb_valid),
    .alu(aluwb),
    .bru_valid(bruwb_valid),
    .bru(bruwb),
    .redirect(bru_redirect),
    .wb_valid(wb_valid),
    .wb(wb),
    .commit_valid(commit_valid),
    .commit(commit),
    .invalidate(invalidate),
    .redirect_pc(redirect_pc)
  );

endmodule

// ==== src/rv_isa_pkg.sv ====
// RV32I integer subset only: no loads, stores, CSRs, fences or system opcodes
package rv_isa_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [6:0]      opcode_t;

  // Major opcodes, instr[6:0]
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    PASS_B
  } alu_op_t;

  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    JAL,
    JALR
  } bru_op_t;

  typedef enum logic {
    UNIT_ALU,
    UNIT_BRU
  } exec_unit_t;

endpackage

// ==== tests/tb_rv_core.sv ====
// Random 64-word program at RESET_VECTOR from seed 64; checks 200 commits against an ISA model
module tb_rv_core
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_WORDS  = 64;
  localparam int N_COMMITS   = 200;
  localparam int CYCLE_LIMIT = N_COMMITS * 12;

  logic   clk;
  logic   reset;
  logic   imem_req;
  word_t  imem_addr;
  logic   imem_rsp;
  word_t  imem_data;
  logic   commit_valid;
  wb_t    commit;

  integer seed;
  word_t  prog [PROG_WORDS];
  logic   is_start [PROG_WORDS];
  logic   jalr_grp [PROG_WORDS];
  word_t  model_pc;
  word_t  model_regs [32];
  wb_t    expected;
  int     errors;
  int     commits;
  int     cycles;
  int     rsp_count;
  int     rsp_wait;
  word_t  rsp_addr;
  logic   timed_out;

  rv_core dut_i (
    .clk(clk),
    .reset(reset),
    .imem_req(imem_req),
    .imem_addr(imem_addr),
    .imem_rsp(imem_rsp),
    .imem_data(imem_data),
    .commit_valid(commit_valid),
    .commit(commit)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic word_t reg_op_word(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                        logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t imm_op_word(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                        reg_idx_t rd, opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t upper_word(logic [19:0] imm, reg_idx_t rd, opcode_t opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t branch_word(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t jal_word(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // Forward target that never lands inside a JALR group
  function automatic int pick_target(int from);
    int t;
    t = from + 1 + int'(rand_below(8));
    if (t > PROG_WORDS - 1) begin
      t = PROG_WORDS - 1;
    end
    while (!is_start[t]) begin
      t--;
    end
    return t;
  endfunction

  task automatic build_program();
    int          i;
    int          k;
    word_t       dest;
    word_t       hi;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [19:0] imm20;
    for (i = 0; i < PROG_WORDS; i++) begin
      is_start[i] = 1'b1;
      jalr_grp[i] = 1'b0;
    end
    // LUI, ADDI, JALR groups
    i = 7;
    while (i < PROG_WORDS - 4) begin
      if (rand_below(8) == 0) begin
        jalr_grp[i]   = 1'b1;
        is_start[i+1] = 1'b0;
        is_start[i+2] = 1'b0;
        i += 3;
      end else begin
        i++;
      end
    end
    // Prologue gives x1..x7 known values
    for (i = 0; i < 7; i++) begin
      prog[i] = imm_op_word(12'(rand_below(4096)), 5'd0, 3'b000, reg_idx_t'(i + 1),
                            OPC_OP_IMM);
    end
    i = 7;
    while (i < PROG_WORDS - 1) begin
      k     = int'(rand_below(16));
      rd    = reg_idx_t'(rand_below(8));
      rs1   = reg_idx_t'(rand_below(8));
      rs2   = reg_idx_t'(rand_below(8));
      f3    = 3'(rand_below(8));
      alt   = (rand_below(2) == 1);
      imm   = 12'(rand_below(4096));
      imm20 = 20'(rand_below(1 << 20));
      if (jalr_grp[i]) begin
        dest      = RESET_VECTOR + word_t'(4 * pick_target(i + 2));
        hi        = (dest + 32'h800) >> 12;
        prog[i]   = upper_word(hi[19:0], 5'd31, OPC_LUI);
        prog[i+1] = imm_op_word(12'(dest - (hi << 12)), 5'd31, 3'b000, 5'd30, OPC_OP_IMM);
        prog[i+2] = imm_op_word(12'd0, 5'd30, 3'b000, rd, OPC_JALR);
        i += 3;
      end else begin
        if (k < 5) begin
          prog[i] = reg_op_word((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                rs2, rs1, f3, rd);
        end else if (k < 10) begin
          if (f3 == 3'd1) begin
            imm = {7'h00, imm[4:0]};
          end else if (f3 == 3'd5) begin
            imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
          end
          prog[i] = imm_op_word(imm, rs1, f3, rd, OPC_OP_IMM);
        end else if (k == 10) begin
          prog[i] = upper_word(imm20, rd, OPC_LUI);
        end else if (k == 11) begin
          prog[i] = upper_word(imm20, rd, OPC_AUIPC);
        end else if (k < 15) begin
          // funct3 2 and 3 are not branches
          if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = f3 ^ 3'b100;
          end
          prog[i] = branch_word(13'(4 * (pick_target(i) - i)), rs2, rs1, f3);
        end else begin
          prog[i] = jal_word(21'(4 * (pick_target(i) - i)), rd);
        end
        i++;
      end
    end
    // Self-loop at the end
    prog[PROG_WORDS-1] = jal_word(21'd0, 5'd0);
  endtask

  function automatic word_t mem_word(word_t addr);
    word_t off;
    word_t fold;
    off  = addr - RESET_VECTOR;
    fold = addr ^ (addr >> 12) ^ (addr >> 24);
    if (off < word_t'(4 * PROG_WORDS)) begin
      return prog[off[31:2]];
    end
    // Outside the image: ADDI x0 with an address-derived immediate
    return imm_op_word(fold[11:0], 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
  endfunction

  function automatic logic signed_less(word_t a, word_t b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  // Executes one instruction on the architectural model
  function automatic wb_t step_model();
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      next_pc;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    logic [2:0] f3;
    reg_idx_t   rd;
    logic       taken;
    wb_t        r;
    ins     = mem_word(model_pc);
    f3      = ins[14:12];
    rd      = ins[11:7];
    a       = model_regs[ins[19:15]];
    b       = model_regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    next_pc = model_pc + 32'd4;
    res     = model_pc + 32'd4;
    case (ins[6:0])
      OPC_OP, OPC_OP_IMM: begin
        if (ins[6:0] == OPC_OP_IMM) begin
          b = imm_i;
        end
        case (f3)
          3'b000:  res = (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
          3'b001:  res = a << b[4:0];
          3'b010:  res = {31'd0, signed_less(a, b)};
          3'b011:  res = {31'd0, a < b};
          3'b100:  res = a ^ b;
          3'b101: begin
            res = a >> b[4:0];
            if (ins[30] && a[31]) begin
              res = res | ~(32'hFFFF_FFFF >> b[4:0]);
            end
          end
          3'b110:  res = a | b;
          default: res = a & b;
        endcase
      end
      OPC_LUI:   res = {ins[31:12], 12'd0};
      OPC_AUIPC: res = model_pc + {ins[31:12], 12'd0};
      OPC_JAL:   next_pc = model_pc + imm_j;
      OPC_JALR:  next_pc = (a + imm_i) & ~32'd1;
      OPC_BRANCH: begin
        rd = 5'd0;
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = signed_less(a, b);
          3'b101:  taken = !signed_less(a, b);
          3'b110:  taken = (a < b);
          default: taken = !(a < b);
        endcase
        if (taken) begin
          next_pc = model_pc + imm_b;
        end
      end
      default: begin
        rd  = 5'd0;
        res = '0;
      end
    endcase
    r.pc        = model_pc;
    r.rd        = rd;
    r.writes_rd = (rd != 5'd0);
    r.value     = res;
    if (rd != 5'd0) begin
      model_regs[rd] = res;
    end
    model_pc = next_pc;
    return r;
  endfunction

  // Memory answers 1 to 4 cycles after each request
  initial begin
    imem_rsp  = 1'b0;
    imem_data = '0;
    rsp_wait  = 0;
    rsp_addr  = '0;
    rsp_count = 0;
    forever begin
      @(posedge clk);
      #2;
      imem_rsp = 1'b0;
      if (rsp_wait > 0) begin
        rsp_wait--;
        if (rsp_wait == 0) begin
          imem_rsp  = 1'b1;
          imem_data = mem_word(rsp_addr);
          rsp_count++;
        end
      end
      if (imem_req === 1'b1) begin
        rsp_addr = imem_addr;
        rsp_wait = 1 + int'(rand_below(4));
      end
    end
  end

  always @(negedge clk) begin
    if (!reset && commit_valid) begin
      expected = step_model();
      if (rsp_count == 0) begin
        errors++;
        $display("ERR %0t: commit at pc %h before any fetch response", $time, commit.pc);
      end
      if (commits == 0 && commit.pc !== RESET_VECTOR) begin
        errors++;
        $display("ERR %0t: first commit pc %h, not the reset vector", $time, commit.pc);
      end
      if (commit.pc !== expected.pc) begin
        errors++;
        $display("ERR %0t: pc %h, expected %h", $time, commit.pc, expected.pc);
      end
      if (commit.rd !== expected.rd) begin
        errors++;
        $display("ERR %0t: pc %h rd %0d, expected %0d", $time, commit.pc, commit.rd,
                 expected.rd);
      end
      if (commit.writes_rd !== expected.writes_rd) begin
        errors++;
        $display("ERR %0t: pc %h writes_rd %b, expected %b", $time, commit.pc,
                 commit.writes_rd, expected.writes_rd);
      end
      if (commit.value !== expected.value) begin
        errors++;
        $display("ERR %0t: pc %h value %h, expected %h", $time, commit.pc, commit.value,
                 expected.value);
      end
      commits++;
    end
  end

  initial begin
    seed      = 64;
    reset     = 1'b1;
    errors    = 0;
    commits   = 0;
    cycles    = 0;
    timed_out = 1'b0;
    model_pc  = RESET_VECTOR;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    build_program();
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    while (commits < N_COMMITS && !timed_out) begin
      @(posedge clk);
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      $display("Timeout: only %0d of %0d commits after %0d cycles", commits, N_COMMITS,
               cycles);
    end
    $display("Commits checked: %0d, errors: %0d, timeouts: %0d", commits, errors,
             timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
